// File: dv/mips_core_tb.sv
`timescale 1ns/100ps

module mips_core_tb import mips_pkg::*; ();

  localparam int max_cycles = 400;  // About four times the program length, stalls included
  localparam int n_stores   = 26;   // Result words the program writes
  localparam logic [31:0] halted_instr = 32'hAC08_00FC;  // SW $t0, 252($zero)

  logic        clk;
  logic        rst_n;
  logic        clk_enable;
  logic [31:0] instr_readdata;
  logic [31:0] data_readdata;
  logic        active;
  logic [31:0] instr_address;
  logic [31:0] data_address;
  logic [31:0] data_writedata;
  logic        data_read;
  logic        data_write;
  logic [31:0] register_v0;

  logic [31:0] imem [128];      // Program image mapped at the reset vector
  logic [31:0] dmem [64];       // Data memory from address zero
  logic [31:0] exp_mem [64];    // Value each result word must receive
  logic        exp_valid [64];  // Words the program is allowed to store to
  logic        jump_at [128];   // Instructions that redirect the fetch
  logic [31:0] jump_to [128];
  logic [31:0] a_word;
  logic [31:0] b_word;
  logic [31:0] c_word;
  logic [31:0] checksum;
  logic [31:0] exp_pc;          // Reference PC and delay-slot register
  logic [31:0] exp_dly;
  logic        exp_active;
  logic [31:0] imem_off;
  logic [31:0] exp_off;
  int          errors;
  int          stores;
  int          cycles;
  int          prog_len;
  int          next_slot;

  mips_core #(
    .data_width(32),
    .reset_vector(reset_vector)
  ) u_mips_core (
    .clk(clk),
    .rst_n(rst_n),
    .clk_enable(clk_enable),
    .instr_readdata(instr_readdata),
    .data_readdata(data_readdata),
    .active(active),
    .instr_address(instr_address),
    .data_address(data_address),
    .data_writedata(data_writedata),
    .data_read(data_read),
    .data_write(data_write),
    .register_v0(register_v0)
  );

  always #20 clk = ~clk;  // 40 ns period

  // Both memories answer in the same cycle
  assign imem_off       = instr_address - reset_vector;
  // A halted core sees a store, which it must not carry out
  assign instr_readdata = !active ? halted_instr :
                          (imem_off < 32'd512) ? imem[imem_off[8:2]] : 32'h0;  // Else a NOP
  assign data_readdata  = dmem[data_address[7:2]];

  always @(posedge clk) begin
    if (!rst_n) begin
      stores <= 0;
    end else if (clk_enable && data_write) begin
      dmem[data_address[7:2]] <= data_writedata;
      stores                  <= stores + 1;
    end
  end

  always @(posedge clk) begin
    if (rst_n) clk_enable <= ($urandom % 8) != 0;  // Roughly one stalled edge in eight
  end

  // Fetch order by the delay-slot rule, redirects land two fetches after the jump
  assign exp_off = exp_pc - reset_vector;

  always @(posedge clk) begin
    if (!rst_n) begin
      exp_pc     <= reset_vector;
      exp_dly    <= reset_vector + 32'd4;
      exp_active <= 1'b1;
    end else if (clk_enable) begin
      if (exp_pc == 32'h0) begin
        exp_active <= 1'b0;  // The core stops once it fetches from zero
      end else begin
        exp_pc  <= exp_dly;
        exp_dly <= jump_at[exp_off[8:2]] ? jump_to[exp_off[8:2]] : exp_dly + 32'd4;
      end
    end
  end

  always @(posedge clk) begin
    if (!rst_n) cycles <= 0;
    else cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("Timeout after %0d cycles, the core never reached its halt", cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  task automatic show_mismatch(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    errors++;
    $display("MISMATCH at %0t: %s expected %h actual %h", $time, name, expected, actual);
  endtask

  task automatic note_failure(input string what);
    errors++;
    $display("ERROR at %0t: %s", $time, what);
  endtask

  // Only the five load opcodes read data memory
  function automatic logic is_load(input logic [5:0] op);
    case (op)
      op_lw, op_lb, op_lbu, op_lh, op_lhu: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // Outputs are checked on the falling edge, half a cycle after they settle
  reset_pc: assert property (@(negedge clk) $rose(rst_n) |-> instr_address == reset_vector)
    else show_mismatch("instr_address", reset_vector, instr_address);
  reset_flags: assert property (@(negedge clk) $rose(rst_n) |-> active && !data_write)
    else note_failure("active is low or data_write is high right after reset");
  fetch_order: assert property (@(negedge clk) disable iff (!rst_n) instr_address == exp_pc)
    else show_mismatch("instr_address", exp_pc, instr_address);
  stall_hold: assert property (@(negedge clk) disable iff (!rst_n)
      $past(rst_n) && !$past(clk_enable) |-> instr_address == $past(instr_address))
    else note_failure("instr_address moved on a disabled edge");
  active_flag: assert property (@(negedge clk) disable iff (!rst_n) active == exp_active)
    else show_mismatch("active", 32'(exp_active), 32'(active));
  halt_hold: assert property (@(negedge clk) disable iff (!rst_n)
      $past(rst_n) && !$past(active) |-> !active && instr_address == $past(instr_address))
    else note_failure("the core left its halted state");
  halt_quiet: assert property (@(negedge clk) disable iff (!rst_n) !active |-> !data_write)
    else note_failure("data_write rose after the halt");
  load_strobe: assert property (@(negedge clk) disable iff (!rst_n)
      data_read == is_load(instr_readdata[31:26]))
    else show_mismatch("data_read", 32'(is_load(instr_readdata[31:26])), 32'(data_read));
  store_target: assert property (@(negedge clk) disable iff (!rst_n)
      data_write |-> data_address[31:8] == '0 && exp_valid[data_address[7:2]])
    else note_failure("store to an address the program never writes, a skipped slot ran");
  store_value: assert property (@(negedge clk) disable iff (!rst_n)
      data_write |-> data_writedata == exp_mem[data_address[7:2]])
    else show_mismatch("data_writedata", exp_mem[data_address[7:2]], data_writedata);
  halt_result: assert property (@(negedge clk) disable iff (!rst_n)
      !active |-> register_v0 == checksum)
    else show_mismatch("register_v0", checksum, register_v0);

  function automatic logic [31:0] r_format(input int rs, input int rt, input int rd,
                                           input int sh, input logic [5:0] funct);
    return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sh), funct};
  endfunction

  function automatic logic [31:0] i_format(input logic [5:0] op, input int rs, input int rt,
                                           input int imm);
    return {op, 5'(rs), 5'(rt), 16'(imm)};
  endfunction

  function automatic logic [31:0] addr_of(input int idx);
    return reset_vector + 32'(4 * idx);
  endfunction

  function automatic logic [31:0] j_format(input logic [5:0] op, input int idx);
    logic [31:0] target;
    target = addr_of(idx);
    return {op, target[27:2]};  // Upper four bits come from the delay slot's segment
  endfunction

  // Big-endian fields, offset zero is the top byte
  function automatic logic [7:0] byte_of(input logic [31:0] w, input int off);
    logic [31:0] s;
    s = w >> (8 * (3 - off));
    return s[7:0];
  endfunction

  function automatic logic [15:0] half_of(input logic [31:0] w, input int off);
    logic [31:0] s;
    s = w >> (8 * (2 - off));
    return s[15:0];
  endfunction

  task automatic emit(input logic [31:0] instr);
    imem[prog_len] = instr;
    prog_len++;
  endtask

  task automatic mark_jump(input int at, input logic [31:0] target);
    jump_at[at] = 1'b1;
    jump_to[at] = target;
  endtask

  // Stores register rt to the next result word and records what it must hold
  task automatic store_check(input int rt, input logic [31:0] value);
    emit(i_format(op_sw, 0, rt, 4 * next_slot));
    exp_mem[next_slot]   = value;
    exp_valid[next_slot] = 1'b1;
    next_slot++;
  endtask

  task automatic build_image();
    logic [7:0]  bt;
    logic [15:0] hw;
    int          j;
    for (int i = 0; i < 128; i++) begin
      imem[i]    = 32'h0;
      jump_at[i] = 1'b0;
      jump_to[i] = 32'h0;
    end
    for (int i = 0; i < 64; i++) begin
      exp_mem[i]   = 32'h0;
      exp_valid[i] = 1'b0;
    end
    emit(i_format(op_lw, 0, 8, 0));   // A, B and C into $t0, $t1, $t2
    emit(i_format(op_lw, 0, 9, 4));
    emit(i_format(op_lw, 0, 10, 8));
    emit(r_format(8, 9, 11, 0, funct_addu));
    store_check(11, a_word + b_word);
    emit(r_format(8, 9, 11, 0, funct_subu));
    store_check(11, a_word - b_word);
    emit(r_format(8, 9, 11, 0, funct_and));
    store_check(11, a_word & b_word);
    emit(r_format(8, 9, 11, 0, funct_or));
    store_check(11, a_word | b_word);
    emit(r_format(8, 9, 11, 0, funct_xor));
    store_check(11, a_word ^ b_word);
    emit(r_format(8, 9, 11, 0, funct_slt));
    store_check(11, ($signed(a_word) < $signed(b_word)) ? 32'd1 : 32'd0);
    emit(r_format(8, 9, 11, 0, funct_sltu));
    store_check(11, (a_word < b_word) ? 32'd1 : 32'd0);
    emit(r_format(0, 8, 11, 5, funct_sll));
    store_check(11, {a_word[26:0], 5'b0});
    emit(r_format(0, 8, 11, 7, funct_sra));
    store_check(11, {{7{a_word[31]}}, a_word[31:7]});
    emit(i_format(op_lui, 0, 11, 16'h8765));
    store_check(11, 32'h8765_0000);
    for (int k = 0; k < 4; k++) begin
      bt = byte_of(c_word, k);
      emit(i_format(op_lb, 0, 11, 8 + k));
      store_check(11, {{24{bt[7]}}, bt});
      emit(i_format(op_lbu, 0, 11, 8 + k));
      store_check(11, {24'h0, bt});
    end
    for (int k = 0; k < 4; k += 2) begin
      hw = half_of(c_word, k);
      emit(i_format(op_lh, 0, 11, 8 + k));
      store_check(11, {{16{hw[15]}}, hw});
      emit(i_format(op_lhu, 0, 11, 8 + k));
      store_check(11, {16'h0, hw});
    end
    mark_jump(prog_len, addr_of(prog_len + 3));
    emit(i_format(op_beq, 8, 8, 2));      // Always taken
    emit(i_format(op_ori, 0, 12, 16'h00AA));  // Delay slot
    emit(i_format(op_sw, 0, 8, 252));     // Skipped
    emit(i_format(op_bne, 8, 8, 5));      // Never taken
    store_check(12, 32'h0000_00AA);       // Runs as the BNE delay slot
    mark_jump(prog_len, addr_of(prog_len + 3));
    emit(j_format(op_j, prog_len + 3));
    emit(i_format(op_ori, 0, 13, 16'h0055));
    emit(i_format(op_sw, 0, 8, 252));     // Skipped
    store_check(13, 32'h0000_0055);
    j = prog_len;
    mark_jump(j, addr_of(j + 8));         // JAL into the subroutine
    mark_jump(j + 5, 32'h0);              // JR $zero halts
    mark_jump(j + 8, addr_of(j + 2));     // JR $ra returns past the delay slot
    emit(j_format(op_jal, j + 8));
    emit(i_format(op_ori, 0, 14, 16'h0033));
    store_check(31, addr_of(j) + 32'd8);  // Link value
    store_check(14, 32'h0000_0033);
    emit(r_format(8, 9, 2, 0, funct_addu));
    emit(r_format(0, 0, 0, 0, funct_jr));
    emit(r_format(2, 10, 2, 0, funct_addu));  // Checksum completes in the delay slot
    emit(i_format(op_sw, 0, 8, 252));     // Never fetched
    emit(r_format(31, 0, 0, 0, funct_jr));
    emit(32'h0);
  endtask

  initial begin
    clk = 1'b0;
    rst_n <= 1'b0;
    clk_enable <= 1'b1;
    errors = 0;
    prog_len = 0;
    next_slot = 16;  // Results start at byte address 64
    void'($urandom(42));
    a_word = $urandom;
    b_word = $urandom;
    c_word = $urandom;
    checksum = a_word + b_word + c_word;
    for (int i = 0; i < 64; i++) begin
      dmem[i] <= 32'hD000_0000 | 32'(4 * i);
    end
    dmem[0] <= a_word;
    dmem[1] <= b_word;
    dmem[2] <= c_word;
    build_image();
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    do @(negedge clk); while (active);
    repeat (12) @(negedge clk);  // The halt checks keep watching for a while
    for (int i = 0; i < 64; i++) begin
      if (exp_valid[i]) begin
        assert (dmem[i] == exp_mem[i])
          else show_mismatch($sformatf("dmem[%0d]", i), exp_mem[i], dmem[i]);
      end
    end
    assert (stores == n_stores)
      else note_failure($sformatf("%0d stores seen, %0d expected", stores, n_stores));
    $display("Errors %0d, stores %0d of %0d, cycles %0d", errors, stores, n_stores, cycles);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: hdl/mips_alu.sv
`timescale 1ns/100ps

module mips_alu import mips_pkg::*; #(
  parameter int unsigned data_width = mips_pkg::data_width
) (
  input  alu_op_t               control,
  input  logic [data_width-1:0] a,
  input  logic [data_width-1:0] b,
  input  logic [4:0]            shamt,
  output logic [data_width-1:0] y,
  output logic                  zero
);

  always_comb begin
    case (control)
      alu_add:  y = a + b;
      alu_sub:  y = a - b;
      alu_and:  y = a & b;
      alu_or:   y = a | b;
      alu_xor:  y = a ^ b;
      alu_nor:  y = ~(a | b);
      // Set-on-less-than yields a single bit at the bottom
      alu_slt:  y = {{(data_width-1){1'b0}}, $signed(a) < $signed(b)};
      alu_sltu: y = {{(data_width-1){1'b0}}, a < b};
      alu_sll:  y = b << shamt;  // Shifts act on rt, not rs
      alu_srl:  y = b >> shamt;
      alu_sra:  y = $unsigned($signed(b) >>> shamt);
      alu_lui:  y = b << 16;     // Immediate moves to the upper half
      default:  y = '0;
    endcase
  end

  assign zero = (y == '0);  // Drives BEQ and BNE through the control unit

endmodule

// File: hdl/mips_control.sv
`timescale 1ns/100ps

module mips_control import mips_pkg::*; (
  input  logic [31:0] instr_data,
  input  logic        zero,        // ALU result was zero, used by BEQ and BNE
  input  logic        active,      // Low once the core has halted
  output logic        memtoreg1,
  output logic        memtoreg2,
  output logic        alusrc,
  output logic        pcsrc,
  output logic        regdst1,
  output logic        regdst2,
  output logic        regwrite,
  output logic        jump,
  output logic        jump1,
  output logic        signext_en,
  output alu_op_t     alucontrol,
  output load_op_t    loadcontrol,
  output logic        data_read,
  output logic        data_write
);

  logic [5:0] opcode;
  logic [5:0] funct;
  logic       reg_we;      // Write enable before the halt mask
  logic       mem_we;      // Store strobe before the halt mask
  logic       is_beq;
  logic       is_bne;

  assign opcode = instr_data[31:26];
  assign funct  = instr_data[5:0];
  assign is_beq = (opcode == op_beq);
  assign is_bne = (opcode == op_bne);

  // Branch condition lives here only, the datapath just follows pcsrc
  assign pcsrc = (is_beq & zero) | (is_bne & ~zero);

  // A halted core must not touch the register file or memory
  assign regwrite   = reg_we & active;
  assign data_write = mem_we & active;

  always_comb begin
    memtoreg1   = 1'b0;  // Defaults describe a NOP
    memtoreg2   = 1'b0;
    alusrc      = 1'b0;
    regdst1     = 1'b0;
    regdst2     = 1'b0;
    reg_we      = 1'b0;
    jump        = 1'b0;
    jump1       = 1'b0;
    signext_en  = 1'b1;
    alucontrol  = alu_add;
    loadcontrol = ld_word;
    data_read   = 1'b0;
    mem_we      = 1'b0;
    case (opcode)
      op_rtype: begin
        regdst1 = 1'b1;  // Destination comes from rd
        reg_we  = 1'b1;
        case (funct)
          funct_addu: alucontrol = alu_add;
          funct_subu: alucontrol = alu_sub;
          funct_and:  alucontrol = alu_and;
          funct_or:   alucontrol = alu_or;
          funct_xor:  alucontrol = alu_xor;
          funct_nor:  alucontrol = alu_nor;
          funct_slt:  alucontrol = alu_slt;
          funct_sltu: alucontrol = alu_sltu;
          funct_sll:  alucontrol = alu_sll;
          funct_srl:  alucontrol = alu_srl;
          funct_sra:  alucontrol = alu_sra;
          funct_jr: begin
            reg_we = 1'b0;  // JR links nothing
            jump   = 1'b1;
            jump1  = 1'b1;
          end
          funct_jalr: begin
            jump      = 1'b1;
            jump1     = 1'b1;
            memtoreg2 = 1'b1;  // Link address into rd
          end
          default: reg_we = 1'b0;  // Unknown function is a NOP
        endcase
      end
      op_addiu: begin
        alusrc = 1'b1;
        reg_we = 1'b1;
      end
      op_andi, op_ori, op_xori: begin
        alusrc     = 1'b1;
        reg_we     = 1'b1;
        signext_en = 1'b0;  // Logic immediates are zero-extended
        alucontrol = (opcode == op_andi) ? alu_and : (opcode == op_ori) ? alu_or : alu_xor;
      end
      op_lui: begin
        alusrc     = 1'b1;
        reg_we     = 1'b1;
        alucontrol = alu_lui;
      end
      op_lw, op_lb, op_lbu, op_lh, op_lhu: begin
        alusrc    = 1'b1;  // Address is base plus offset
        reg_we    = 1'b1;
        memtoreg1 = 1'b1;
        data_read = 1'b1;
        case (opcode)
          op_lb:   loadcontrol = ld_byte;
          op_lbu:  loadcontrol = ld_byte_u;
          op_lh:   loadcontrol = ld_half;
          op_lhu:  loadcontrol = ld_half_u;
          default: loadcontrol = ld_word;
        endcase
      end
      op_sw: begin
        alusrc = 1'b1;
        mem_we = 1'b1;
      end
      op_beq, op_bne: alucontrol = alu_sub;  // Zero flag compares rs and rt
      op_j: jump = 1'b1;
      op_jal: begin
        jump      = 1'b1;
        reg_we    = 1'b1;
        regdst2   = 1'b1;  // Link into register 31
        memtoreg2 = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

// File: hdl/mips_core.sv
`timescale 1ns/100ps

module mips_core import mips_pkg::*; #(
  parameter int unsigned           data_width   = mips_pkg::data_width,
  parameter logic [data_width-1:0] reset_vector = mips_pkg::reset_vector
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  clk_enable,
  input  logic [31:0]           instr_readdata,
  input  logic [data_width-1:0] data_readdata,
  output logic                  active,
  output logic [data_width-1:0] instr_address,
  output logic [data_width-1:0] data_address,
  output logic [data_width-1:0] data_writedata,
  output logic                  data_read,
  output logic                  data_write,
  output logic [data_width-1:0] register_v0
);

  logic        memtoreg1, memtoreg2, alusrc, pcsrc;
  logic        regdst1, regdst2, regwrite;
  logic        jump, jump1, signext_en, zero;
  alu_op_t     alucontrol;
  load_op_t    loadcontrol;
  logic [31:0] instr_data;

  mips_control u_control (
    .instr_data(instr_data),
    .zero(zero),
    .active(active),
    .memtoreg1(memtoreg1),
    .memtoreg2(memtoreg2),
    .alusrc(alusrc),
    .pcsrc(pcsrc),
    .regdst1(regdst1),
    .regdst2(regdst2),
    .regwrite(regwrite),
    .jump(jump),
    .jump1(jump1),
    .signext_en(signext_en),
    .alucontrol(alucontrol),
    .loadcontrol(loadcontrol),
    .data_read(data_read),
    .data_write(data_write)
  );

  mips_datapath #(
    .data_width(data_width),
    .reset_vector(reset_vector)
  ) u_datapath (
    .clk(clk),
    .rst_n(rst_n),
    .clk_enable(clk_enable),
    .memtoreg1(memtoreg1),
    .memtoreg2(memtoreg2),
    .alusrc(alusrc),
    .pcsrc(pcsrc),
    .regdst1(regdst1),
    .regdst2(regdst2),
    .regwrite(regwrite),
    .jump(jump),
    .jump1(jump1),
    .signext_en(signext_en),
    .alucontrol(alucontrol),
    .loadcontrol(loadcontrol),
    .instr_readdata(instr_readdata),
    .data_readdata(data_readdata),
    .active(active),
    .zero(zero),
    .instr_address(instr_address),
    .instr_data(instr_data),
    .data_address(data_address),
    .data_writedata(data_writedata),
    .register_v0(register_v0)
  );

endmodule

// File: hdl/mips_datapath.sv
`timescale 1ns/100ps

module mips_datapath import mips_pkg::*; #(
  parameter int unsigned           data_width   = mips_pkg::data_width,
  parameter logic [data_width-1:0] reset_vector = mips_pkg::reset_vector
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  clk_enable,
  input  logic                  memtoreg1,
  input  logic                  memtoreg2,
  input  logic                  alusrc,
  input  logic                  pcsrc,
  input  logic                  regdst1,
  input  logic                  regdst2,
  input  logic                  regwrite,
  input  logic                  jump,
  input  logic                  jump1,
  input  logic                  signext_en,
  input  alu_op_t               alucontrol,
  input  load_op_t              loadcontrol,
  input  logic [31:0]           instr_readdata,
  input  logic [data_width-1:0] data_readdata,
  output logic                  active,
  output logic                  zero,
  output logic [data_width-1:0] instr_address,
  output logic [31:0]           instr_data,
  output logic [data_width-1:0] data_address,
  output logic [data_width-1:0] data_writedata,
  output logic [data_width-1:0] register_v0
);

  logic [data_width-1:0]     pc_delay;    // Delay slot register, the PC of the next fetch
  logic [data_width-1:0]     pc_plus4;
  logic [data_width-1:0]     pc_link;     // Return address past the delay slot
  logic [data_width-1:0]     pc_seq;
  logic [data_width-1:0]     pc_branch;
  logic [data_width-1:0]     pc_jump;
  logic [data_width-1:0]     pc_next;
  logic [data_width-1:0]     imm_ext;
  logic [data_width-1:0]     src_a;
  logic [data_width-1:0]     src_b;
  logic [data_width-1:0]     alu_y;
  logic [data_width-1:0]     load_y;
  logic [data_width-1:0]     result;
  logic [reg_addr_width-1:0] write_reg;
  logic                      fetch_halt;

  assign instr_data = instr_readdata;  // No scheduler, fetch goes straight to decode

  assign fetch_halt = (instr_address == '0);  // A jump to zero ends the program

  // Immediate is sign- or zero-extended as the opcode needs
  assign imm_ext = signext_en ? {{(data_width-16){instr_data[15]}}, instr_data[15:0]}
                              : {{(data_width-16){1'b0}}, instr_data[15:0]};

  assign pc_plus4  = instr_address + data_width'(4);
  assign pc_link   = instr_address + data_width'(8);
  assign pc_seq    = pc_delay + data_width'(4);      // Fetch after the one already queued
  assign pc_branch = pc_plus4 + (imm_ext << 2);      // Relative to the delay slot

  // J and JAL splice the index into the delay slot's segment, JR and JALR use rs
  assign pc_jump = jump1 ? src_a : {pc_plus4[data_width-1:28], instr_data[25:0], 2'b00};

  always_comb begin
    if (jump) pc_next = pc_jump;
    else if (pcsrc) pc_next = pc_branch;
    else pc_next = pc_seq;
  end

  // The PC takes the queued address, the queue takes the new target,
  // so every redirect lands two edges after the branch is fetched
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      instr_address <= reset_vector;
      pc_delay      <= reset_vector + data_width'(4);
      active        <= 1'b1;
    end else if (clk_enable) begin
      if (fetch_halt) active <= 1'b0;  // Stays low, the PC is frozen at zero
      if (active && !fetch_halt) begin
        instr_address <= pc_delay;
        pc_delay      <= pc_next;
      end
    end
  end

  // Destination is rt for I-type, rd for R-type, or $ra for JAL
  always_comb begin
    if (regdst2) write_reg = reg_addr_width'(31);
    else if (regdst1) write_reg = instr_data[15:11];
    else write_reg = instr_data[20:16];
  end

  always_comb begin
    if (memtoreg2) result = pc_link;
    else if (memtoreg1) result = load_y;
    else result = alu_y;
  end

  mips_regfile #(
    .data_width(data_width)
  ) u_regfile (
    .clk(clk),
    .rst_n(rst_n),
    .clk_enable(clk_enable),
    .we(regwrite),
    .ra1(instr_data[25:21]),
    .ra2(instr_data[20:16]),
    .wa(write_reg),
    .wd(result),
    .rd1(src_a),
    .rd2(data_writedata),   // rt is also the store data
    .reg_v0(register_v0)
  );

  assign src_b = alusrc ? imm_ext : data_writedata;

  mips_alu #(
    .data_width(data_width)
  ) u_alu (
    .control(alucontrol),
    .a(src_a),
    .b(src_b),
    .shamt(instr_data[10:6]),
    .y(alu_y),
    .zero(zero)
  );

  assign data_address = alu_y;  // Loads and stores address through the ALU

  mips_load_unit u_load_unit (
    .readdata(data_readdata),
    .byte_offset(alu_y[1:0]),
    .control(loadcontrol),
    .y(load_y)
  );

endmodule

// File: hdl/mips_load_unit.sv
`timescale 1ns/100ps

module mips_load_unit import mips_pkg::*; (
  input  logic [31:0] readdata,
  input  logic [1:0]  byte_offset,  // Low bits of the data address
  input  load_op_t    control,
  output logic [31:0] y
);

  logic [7:0]  sel_byte;
  logic [15:0] sel_half;

  // Big-endian word, so offset 0 is the most significant byte
  always_comb begin
    case (byte_offset)
      2'd0:    sel_byte = readdata[31:24];
      2'd1:    sel_byte = readdata[23:16];
      2'd2:    sel_byte = readdata[15:8];
      default: sel_byte = readdata[7:0];
    endcase
  end

  assign sel_half = byte_offset[1] ? readdata[15:0] : readdata[31:16];  // Bit 0 is ignored

  always_comb begin
    case (control)
      ld_byte:   y = {{24{sel_byte[7]}}, sel_byte};
      ld_byte_u: y = {24'b0, sel_byte};
      ld_half:   y = {{16{sel_half[15]}}, sel_half};
      ld_half_u: y = {16'b0, sel_half};
      default:   y = readdata;  // LW takes the whole word
    endcase
  end

endmodule

// File: hdl/mips_pkg.sv
package mips_pkg;

  localparam int unsigned data_width = 32;     // Machine word width
  localparam int unsigned reg_addr_width = 5;  // 32 architectural registers
  localparam logic [31:0] reset_vector = 32'hBFC0_0000;  // First fetch after reset

  // ALU operations, 5-bit code driven by the control unit
  typedef enum logic [4:0] {
    alu_add, alu_sub,
    alu_and, alu_or, alu_xor, alu_nor,
    alu_slt, alu_sltu,
    alu_sll, alu_srl, alu_sra,
    alu_lui
  } alu_op_t;

  // Load width and extension selected by the opcode
  typedef enum logic [2:0] {
    ld_word, ld_byte, ld_byte_u, ld_half, ld_half_u
  } load_op_t;

  // Primary opcodes, instr[31:26]
  localparam logic [5:0] op_rtype = 6'h00;
  localparam logic [5:0] op_j     = 6'h02;
  localparam logic [5:0] op_jal   = 6'h03;
  localparam logic [5:0] op_beq   = 6'h04;
  localparam logic [5:0] op_bne   = 6'h05;
  localparam logic [5:0] op_addiu = 6'h09;
  localparam logic [5:0] op_andi  = 6'h0C;
  localparam logic [5:0] op_ori   = 6'h0D;
  localparam logic [5:0] op_xori  = 6'h0E;
  localparam logic [5:0] op_lui   = 6'h0F;
  localparam logic [5:0] op_lb    = 6'h20;
  localparam logic [5:0] op_lh    = 6'h21;
  localparam logic [5:0] op_lw    = 6'h23;
  localparam logic [5:0] op_lbu   = 6'h24;
  localparam logic [5:0] op_lhu   = 6'h25;
  localparam logic [5:0] op_sw    = 6'h2B;

  // Function codes of R-type instructions, instr[5:0]
  localparam logic [5:0] funct_sll  = 6'h00;
  localparam logic [5:0] funct_srl  = 6'h02;
  localparam logic [5:0] funct_sra  = 6'h03;
  localparam logic [5:0] funct_jr   = 6'h08;
  localparam logic [5:0] funct_jalr = 6'h09;
  localparam logic [5:0] funct_addu = 6'h21;
  localparam logic [5:0] funct_subu = 6'h23;
  localparam logic [5:0] funct_and  = 6'h24;
  localparam logic [5:0] funct_or   = 6'h25;
  localparam logic [5:0] funct_xor  = 6'h26;
  localparam logic [5:0] funct_nor  = 6'h27;
  localparam logic [5:0] funct_slt  = 6'h2A;
  localparam logic [5:0] funct_sltu = 6'h2B;

endpackage

// File: hdl/mips_regfile.sv
`timescale 1ns/100ps

module mips_regfile import mips_pkg::*; #(
  parameter int unsigned data_width = mips_pkg::data_width
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      clk_enable,
  input  logic                      we,
  input  logic [reg_addr_width-1:0] ra1,
  input  logic [reg_addr_width-1:0] ra2,
  input  logic [reg_addr_width-1:0] wa,
  input  logic [data_width-1:0]     wd,
  output logic [data_width-1:0]     rd1,
  output logic [data_width-1:0]     rd2,
  output logic [data_width-1:0]     reg_v0
);

  logic [data_width-1:0] regs [2**reg_addr_width];

  // Entry zero is cleared by reset and never written, so it always reads zero
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 2**reg_addr_width; i++) begin
        regs[i] <= '0;
      end
    end else if (clk_enable && we && (wa != '0)) begin
      regs[wa] <= wd;
    end
  end

  assign rd1    = regs[ra1];  // Reads are combinational
  assign rd2    = regs[ra2];
  assign reg_v0 = regs[2];    // $v0 carries the program result out

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module mips_core_tb -f tb.f -o mips_core_sim
output=$(./obj_dir/mips_core_sim)
echo "$output"

if echo "$output" | grep -qx "ALL TESTS PASSED"; then
  exit 0
fi
exit 1

// File: tb.f
hdl/mips_pkg.sv
hdl/mips_alu.sv
hdl/mips_regfile.sv
hdl/mips_load_unit.sv
hdl/mips_control.sv
hdl/mips_datapath.sv
hdl/mips_core.sv
dv/mips_core_tb.sv
